/* sim.f */
verilog/l1d_pkg.sv
verilog/l1d_valid_bits.sv
verilog/l1d_store_align.sv
verilog/l1d_data_array.sv
verilog/l1d_tag_array.sv
verilog/l1d_ctrl.sv
verilog/l1d_cache.sv
tests/l1d_assert.sv
tests/tb_l1d.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_l1d -o tb_l1d

./obj_dir/tb_l1d | tee sim.log

if grep -q "^TEST OK$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

/* tests/tb_l1d.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_l1d;
  import l1d_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int STALL_PCT    = 30;   // Chance of D_wait per cycle
  localparam int MAX_STALL    = 3;    // Longest run of stalled cycles
  localparam int N_OPS        = 26;
  localparam int OP_CYCLES    = WORDS_PER_LINE * (MAX_STALL + 1) + 8;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + 4 + N_OPS * OP_CYCLES) * CLK_PERIOD;

  logic    clk;
  logic    rst;
  logic    core_req;
  logic    core_write;
  addr_t   core_addr;
  word_t   core_in;
  access_t core_type;
  word_t   core_out;
  logic    core_wait;
  logic    D_req;
  logic    D_write;
  addr_t   D_addr;
  word_t   D_in;
  access_t D_type;
  word_t   D_out;
  logic    D_wait;

  word_t   mem_model [addr_t];   // Sparse, word addressed
  word_t   shadow [addr_t];
  word_t   expect_q [$];
  addr_t   expect_addr_q [$];
  addr_t   beat_addr_q [$];
  logic    beat_wr_q [$];
  access_t beat_type_q [$];
  word_t   beat_data_q [$];
  int      dreq_cycles;
  integer  seed = 45274;
  int      stall_run;
  logic    stall;
  logic    wait_prev;
  word_t   exp_word;
  addr_t   exp_addr;
  int      errors;
  int      errors_at_start;
  int      tests_passed;
  int      tests_failed;

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  l1d_cache u_l1d_cache (
    .clk        (clk),
    .rst        (rst),
    .core_req   (core_req),
    .core_write (core_write),
    .core_addr  (core_addr),
    .core_in    (core_in),
    .core_type  (core_type),
    .core_out   (core_out),
    .core_wait  (core_wait),
    .D_req      (D_req),
    .D_write    (D_write),
    .D_addr     (D_addr),
    .D_in       (D_in),
    .D_type     (D_type),
    .D_out      (D_out),
    .D_wait     (D_wait)
  );

  // ====================
  // Reference model
  // ====================
  function automatic addr_t make_addr(input logic [31:0] tag, input logic [31:0] idx,
                                      input logic [31:0] off);
    return {tag[TAG_W-1:0], idx[INDEX_W-1:0], off[3:0]};
  endfunction

  // Power-up memory contents
  function automatic word_t init_word(input addr_t a);
    return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ 32'h5A3C_C3A5;
  endfunction

  function automatic word_t merge_store(input word_t old, input addr_t a, input word_t data,
                                        input access_t typ);
    word_t res;
    res = old;
    case (typ)
      ACC_BYTE, ACC_BYTE_U: res[8 * a[1:0] +: 8] = data[7:0];
      ACC_HALF, ACC_HALF_U: res[16 * a[1] +: 16] = data[15:0];
      ACC_WORD:             res = data;
      default:              res = old;
    endcase
    return res;
  endfunction

  function automatic word_t model_word(input addr_t wa);
    if (mem_model.exists(wa))
      return mem_model[wa];
    return init_word(wa);
  endfunction

  function automatic word_t expected_word(input addr_t a);
    addr_t wa;
    wa = {a[ADDR_W-1:2], 2'b00};
    if (shadow.exists(wa))
      return shadow[wa];
    return init_word(wa);
  endfunction

  // ====================
  // Memory side
  // ====================
  always @(negedge clk)
  begin
    if (rst)
    begin
      D_wait    = 1'b0;
      stall_run = 0;
    end
    else
    begin
      stall     = (({$random(seed)} % 100) < STALL_PCT) && (stall_run < MAX_STALL);
      stall_run = stall ? stall_run + 1 : 0;
      D_wait    = stall;
      if (D_req)
        dreq_cycles++;
      if (D_req && !stall)   // Beat completes at the next rising edge
      begin
        beat_addr_q.push_back(D_addr);
        beat_wr_q.push_back(D_write);
        beat_type_q.push_back(D_type);
        beat_data_q.push_back(D_in);
        if (D_write)
          mem_model[{D_addr[ADDR_W-1:2], 2'b00}] =
            merge_store(model_word({D_addr[ADDR_W-1:2], 2'b00}), D_addr, D_in, D_type);
        else
          D_out = model_word({D_addr[ADDR_W-1:2], 2'b00});
      end
    end
  end

  // Read data check when core_wait falls
  always @(negedge clk)
  begin
    if (rst)
      wait_prev = 1'b0;
    else
    begin
      if (wait_prev && !core_wait && expect_q.size() > 0)
      begin
        exp_word = expect_q.pop_front();
        exp_addr = expect_addr_q.pop_front();
        assert (core_out == exp_word)
        else
        begin
          $display("Fail %0t: read of %h returned %h, expected %h",
                   $time, exp_addr, core_out, exp_word);
          errors++;
        end
      end
      wait_prev = core_wait;
    end
  end

  // ====================
  // Stimulus helpers
  // ====================
  task automatic verify(input logic ok, input string what);
    assert (ok)
    else
    begin
      $display("Fail %0t: %s", $time, what);
      errors++;
    end
  endtask

  task automatic run_op(input logic wr, input addr_t a, input word_t d, input access_t t,
                        output int wait_cycles);
    beat_addr_q.delete();
    beat_wr_q.delete();
    beat_type_q.delete();
    beat_data_q.delete();
    dreq_cycles = 0;
    if (wr)
      shadow[{a[ADDR_W-1:2], 2'b00}] = merge_store(expected_word(a), a, d, t);
    else
    begin
      expect_q.push_back(expected_word(a));
      expect_addr_q.push_back(a);
    end
    core_req   = 1'b1;
    core_write = wr;
    core_addr  = a;
    core_in    = d;
    core_type  = t;
    @(negedge clk);
    core_req    = 1'b0;
    wait_cycles = 0;
    while (core_wait)
    begin
      wait_cycles++;
      @(negedge clk);
    end
    @(negedge clk);   // Checker has seen the result
  endtask

  task automatic inspect_refill(input addr_t a);
    addr_t base;
    base = {a[ADDR_W-1:4], 4'h0};
    verify(beat_addr_q.size() == WORDS_PER_LINE,
           $sformatf("%0d refill beats for %h, expected 4", beat_addr_q.size(), a));
    for (int i = 0; i < beat_addr_q.size() && i < WORDS_PER_LINE; i++)
    begin
      verify(!beat_wr_q[i] && beat_type_q[i] == ACC_WORD && beat_addr_q[i] == base + 4 * i,
             $sformatf("refill beat %0d went to %h type %0d write %b", i,
                       beat_addr_q[i], beat_type_q[i], beat_wr_q[i]));
    end
  endtask

  task automatic inspect_write_beat(input addr_t a, input word_t d, input access_t t);
    verify(beat_addr_q.size() == 1,
           $sformatf("%0d write beats for %h, expected 1", beat_addr_q.size(), a));
    if (beat_addr_q.size() > 0)
      verify(beat_wr_q[0] && beat_addr_q[0] == a && beat_data_q[0] == d && beat_type_q[0] == t,
             $sformatf("write beat %h %h type %0d, expected %h %h type %0d",
                       beat_addr_q[0], beat_data_q[0], beat_type_q[0], a, d, t));
  endtask

  task automatic store_and_readback(input addr_t a, input word_t d, input access_t t);
    int cycles;
    run_op(1'b1, a, d, t, cycles);
    inspect_write_beat(a, d, t);
    run_op(1'b0, {a[ADDR_W-1:2], 2'b00}, '0, ACC_WORD, cycles);
    verify(dreq_cycles == 0, $sformatf("D_req seen on read back after store to %h", a));
  endtask

  task automatic start_test;
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == errors_at_start)
    begin
      tests_passed++;
      $display("%s: passed", name);
    end
    else
    begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - errors_at_start);
    end
  endtask

  // ====================
  // Tests
  // ====================
  initial
  begin
    addr_t a;
    addr_t b;
    int    cycles;
    rst          = 1'b1;
    core_req     = 1'b0;
    core_write   = 1'b0;
    core_addr    = '0;
    core_in      = '0;
    core_type    = ACC_WORD;
    D_out        = '0;
    D_wait       = 1'b0;
    dreq_cycles  = 0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    start_test();
    verify(!core_wait && !D_req, "core_wait or D_req high after reset");
    end_test("reset");

    a = make_addr(32'h1234, 5, 8);
    start_test();
    run_op(1'b0, a, '0, ACC_WORD, cycles);
    inspect_refill(a);
    end_test("read miss");

    start_test();
    run_op(1'b0, a + 4, '0, ACC_WORD, cycles);
    verify(dreq_cycles == 0, "D_req seen on read hit");
    verify(cycles == 1, $sformatf("read hit held core_wait for %0d cycles", cycles));
    end_test("read hit");

    // All lanes of one cached line
    b = make_addr(32'h1234, 5, 0);
    start_test();
    store_and_readback(b,     32'hA1B2_C3D4, ACC_BYTE);
    store_and_readback(b + 1, 32'h0000_0055, ACC_BYTE_U);
    store_and_readback(b + 2, 32'h1234_5677, ACC_BYTE);
    store_and_readback(b + 3, 32'hFFFF_FF80, ACC_BYTE_U);
    store_and_readback(b + 4, 32'hDEAD_BEEF, ACC_HALF);
    store_and_readback(b + 6, 32'h0BAD_F00D, ACC_HALF_U);
    store_and_readback(b + 8, 32'hCAFE_0123, ACC_WORD);
    end_test("stores to cached line");

    a = make_addr(32'h2_0F0F, 9, 4);
    start_test();
    run_op(1'b1, a, 32'h7654_3210, ACC_WORD, cycles);
    inspect_write_beat(a, 32'h7654_3210, ACC_WORD);
    run_op(1'b0, a, '0, ACC_WORD, cycles);
    verify(dreq_cycles > 0, "no D_req on read after write miss");
    inspect_refill(a);
    end_test("write miss");

    // Same index, two tags
    start_test();
    for (int r = 0; r < 4; r++)
    begin
      a = make_addr(32'h0_0AAA, 17, 4 * r);
      run_op(1'b0, a, '0, ACC_WORD, cycles);
      inspect_refill(a);
      b = make_addr(32'h3_1555, 17, 12 - 4 * r);
      run_op(1'b0, b, '0, ACC_WORD, cycles);
      inspect_refill(b);
    end
    end_test("eviction");

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Sized from op count and worst refill stall
  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, a handshake never completed", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/l1d_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module l1d_assert (
  input logic               clk,
  input logic               rst,
  input logic               core_wait,
  input logic               D_req,
  input logic               D_write,
  input l1d_pkg::addr_t     D_addr,
  input l1d_pkg::word_t     D_in,
  input l1d_pkg::access_t   D_type,
  input logic               D_wait
);

  // Back-pressure holds the whole request
  a_dreq_stable: assert property (@(posedge clk) disable iff (rst)
    (D_req && D_wait) |=> (D_req && $stable(D_write) && $stable(D_addr) &&
                           $stable(D_in) && $stable(D_type)))
    else $error("memory request changed while D_wait was high");

  a_write_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(D_write) |-> D_req)
    else $error("D_write rose without D_req");

  // First cycle out of reset
  a_reset_idle: assert property (@(posedge clk)
    $fell(rst) |-> (!core_wait && !D_req))
    else $error("core_wait or D_req high right after reset release");

endmodule

bind l1d_cache l1d_assert u_l1d_assert (
  .clk       (clk),
  .rst       (rst),
  .core_wait (core_wait),
  .D_req     (D_req),
  .D_write   (D_write),
  .D_addr    (D_addr),
  .D_in      (D_in),
  .D_type    (D_type),
  .D_wait    (D_wait)
);

`default_nettype wire

/* verilog/l1d_cache.sv */
`timescale 1ns/10ps
`default_nettype none

module l1d_cache (
  input  logic               clk,
  input  logic               rst,
  input  logic               core_req,
  input  logic               core_write,
  input  l1d_pkg::addr_t     core_addr,
  input  l1d_pkg::word_t     core_in,
  input  l1d_pkg::access_t   core_type,
  output l1d_pkg::word_t     core_out,
  output logic               core_wait,
  output logic               D_req,
  output logic               D_write,
  output l1d_pkg::addr_t     D_addr,
  output l1d_pkg::word_t     D_in,
  output l1d_pkg::access_t   D_type,
  input  l1d_pkg::word_t     D_out,
  input  logic               D_wait
);
  import l1d_pkg::*;

  index_t   index;
  logic     array_rd;
  logic     valid;
  logic     valid_set;
  tag_t     tag_rd;
  logic     tag_wr;
  tag_t     tag_wd;
  line_t    line_rd;
  byte_en_t line_wr_en;
  line_t    line_wd;
  offset_t  st_offset;
  access_t  st_type;
  word_t    st_data;
  line_t    store_line;
  byte_en_t store_en;

  l1d_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .core_req   (core_req),
    .core_write (core_write),
    .core_addr  (core_addr),
    .core_in    (core_in),
    .core_type  (core_type),
    .core_out   (core_out),
    .core_wait  (core_wait),
    .D_req      (D_req),
    .D_write    (D_write),
    .D_addr     (D_addr),
    .D_in       (D_in),
    .D_type     (D_type),
    .D_out      (D_out),
    .D_wait     (D_wait),
    .index      (index),
    .array_rd   (array_rd),
    .valid      (valid),
    .valid_set  (valid_set),
    .tag_rd     (tag_rd),
    .tag_wr     (tag_wr),
    .tag_wd     (tag_wd),
    .line_rd    (line_rd),
    .line_wr_en (line_wr_en),
    .line_wd    (line_wd),
    .st_offset  (st_offset),
    .st_type    (st_type),
    .st_data    (st_data),
    .store_line (store_line),
    .store_en   (store_en)
  );

  l1d_valid_bits u_valid_bits (
    .clk       (clk),
    .rst       (rst),
    .index     (index),
    .valid_set (valid_set),
    .valid     (valid)
  );

  l1d_store_align u_store_align (
    .st_offset  (st_offset),
    .st_type    (st_type),
    .st_data    (st_data),
    .store_line (store_line),
    .store_en   (store_en)
  );

  l1d_data_array u_data_array (
    .clk   (clk),
    .index (index),
    .rd    (array_rd),
    .wr_en (line_wr_en),
    .wd    (line_wd),
    .rdata (line_rd)
  );

  l1d_tag_array u_tag_array (
    .clk   (clk),
    .index (index),
    .rd    (array_rd),
    .wr    (tag_wr),
    .wd    (tag_wd),
    .rdata (tag_rd)
  );

endmodule

`default_nettype wire

/* verilog/l1d_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module l1d_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  logic                core_req,
  input  logic                core_write,
  input  l1d_pkg::addr_t      core_addr,
  input  l1d_pkg::word_t      core_in,
  input  l1d_pkg::access_t    core_type,
  output l1d_pkg::word_t      core_out,
  output logic                core_wait,
  output logic                D_req,
  output logic                D_write,
  output l1d_pkg::addr_t      D_addr,
  output l1d_pkg::word_t      D_in,
  output l1d_pkg::access_t    D_type,
  input  l1d_pkg::word_t      D_out,
  input  logic                D_wait,
  output l1d_pkg::index_t     index,
  output logic                array_rd,
  input  logic                valid,
  output logic                valid_set,
  input  l1d_pkg::tag_t       tag_rd,
  output logic                tag_wr,
  output l1d_pkg::tag_t       tag_wd,
  input  l1d_pkg::line_t      line_rd,
  output l1d_pkg::byte_en_t   line_wr_en,
  output l1d_pkg::line_t      line_wd,
  output l1d_pkg::offset_t    st_offset,
  output l1d_pkg::access_t    st_type,
  output l1d_pkg::word_t      st_data,
  input  l1d_pkg::line_t      store_line,
  input  l1d_pkg::byte_en_t   store_en
);
  import l1d_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nx;
  addr_t       req_addr;
  word_t       req_data;
  access_t     req_type;
  tag_t        req_tag;
  index_t      req_index;
  offset_t     req_offset;
  logic [1:0]  word_sel;
  logic [1:0]  beat;          // Refill beat number
  line_t       refill_line;
  logic        hit;
  logic        wr_hit;        // High on first write_mem cycle of a hit
  logic        beat_done;
  logic        take_req;

  assign take_req   = (state == st_idle) && core_req;
  assign req_tag    = req_addr[ADDR_W-1 -: TAG_W];
  assign req_index  = req_addr[OFFSET_W +: INDEX_W];
  assign req_offset = req_addr[OFFSET_W-1:0];
  assign word_sel   = req_offset[3:2];
  assign hit        = valid && (tag_rd == req_tag);
  assign beat_done  = D_req && !D_wait;

  // ====================
  // State machine
  // ====================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= st_idle;
    else
      state <= state_nx;
  end

  always_comb
  begin
    state_nx = state;
    case (state)
      st_idle:
      begin
        if (core_req)
          state_nx = core_write ? st_check_write : st_check_read;
      end
      st_check_read:  state_nx = hit ? st_idle : st_refill;
      st_refill:
      begin
        if (beat_done && beat == 2'd3)
          state_nx = st_install;
      end
      st_install:     state_nx = st_idle;
      st_check_write: state_nx = st_write_mem;
      st_write_mem:
      begin
        if (beat_done)
          state_nx = st_idle;
      end
      default:        state_nx = st_idle;
    endcase
  end

  // ====================
  // Request and refill data
  // ====================
  always_ff @(posedge clk)
  begin
    if (take_req)
    begin
      req_addr <= core_addr;
      req_data <= core_in;
      req_type <= core_type;
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == st_refill && beat_done)
      refill_line[{beat, 5'd0} +: WORD_W] <= D_out;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      beat     <= 2'd0;
      wr_hit   <= 1'b0;
      core_out <= '0;
    end
    else
    begin
      if (state == st_refill && beat_done)
        beat <= beat + 2'd1;   // Wraps to 0 after the last beat
      wr_hit <= (state == st_check_write) && hit;
      if (state == st_check_read && hit)
        core_out <= line_rd[{word_sel, 5'd0} +: WORD_W];
      else if (state == st_install)
        core_out <= refill_line[{word_sel, 5'd0} +: WORD_W];
    end
  end

  // Core and memory side
  assign core_wait = (state != st_idle);
  assign D_req     = (state == st_refill) || (state == st_write_mem);
  assign D_write   = (state == st_write_mem);
  assign D_addr    = D_write ? req_addr : {req_tag, req_index, beat, 2'b00};
  assign D_in      = req_data;
  assign D_type    = D_write ? req_type : ACC_WORD;

  // Arrays, valid flags and store path
  assign index     = take_req ? core_addr[OFFSET_W +: INDEX_W] : req_index;
  assign array_rd  = take_req;
  assign valid_set = (state == st_install);
  assign tag_wr    = (state == st_install);
  assign tag_wd    = req_tag;
  assign line_wd   = (state == st_install) ? refill_line : store_line;

  always_comb
  begin
    if (state == st_install)
      line_wr_en = {LINE_BYTES{1'b1}};
    else if (wr_hit)
      line_wr_en = store_en;
    else
      line_wr_en = {LINE_BYTES{1'b0}};
  end

  assign st_offset = req_offset;
  assign st_type   = req_type;
  assign st_data   = req_data;

endmodule

`default_nettype wire

/* verilog/l1d_tag_array.sv */
`timescale 1ns/10ps
`default_nettype none

module l1d_tag_array (
  input  logic              clk,
  input  l1d_pkg::index_t   index,
  input  logic              rd,
  input  logic              wr,
  input  l1d_pkg::tag_t     wd,
  output l1d_pkg::tag_t     rdata
);
  import l1d_pkg::*;

  tag_t mem [LINES];

  always_ff @(posedge clk)
  begin
    if (wr)
      mem[index] <= wd;
    if (rd)
      rdata <= mem[index];  // Registered read
  end

endmodule

`default_nettype wire

/* verilog/l1d_data_array.sv */
`timescale 1ns/10ps
`default_nettype none

module l1d_data_array (
  input  logic                clk,
  input  l1d_pkg::index_t     index,
  input  logic                rd,
  input  l1d_pkg::byte_en_t   wr_en,
  input  l1d_pkg::line_t      wd,
  output l1d_pkg::line_t      rdata
);
  import l1d_pkg::*;

  line_t mem [LINES];

  // Per-byte write
  always_ff @(posedge clk)
  begin
    for (int b = 0; b < LINE_BYTES; b++)
    begin
      if (wr_en[b])
        mem[index][b*8 +: 8] <= wd[b*8 +: 8];
    end
  end

  // Output holds until the next read
  always_ff @(posedge clk)
  begin
    if (rd)
      rdata <= mem[index];
  end

endmodule

`default_nettype wire

/* verilog/l1d_store_align.sv */
`timescale 1ns/10ps
`default_nettype none

module l1d_store_align (
  input  l1d_pkg::offset_t  st_offset,
  input  l1d_pkg::access_t  st_type,
  input  l1d_pkg::word_t    st_data,
  output l1d_pkg::line_t    store_line,
  output l1d_pkg::byte_en_t store_en
);
  import l1d_pkg::*;

  word_t      lane_data;
  logic [3:0] lane_en;    // Byte enables inside one word

  always_comb
  begin
    case (st_type)
      ACC_BYTE, ACC_BYTE_U:
      begin
        lane_data = {4{st_data[7:0]}};
        lane_en   = 4'b0001 << st_offset[1:0];
      end
      ACC_HALF, ACC_HALF_U:
      begin
        lane_data = {2{st_data[15:0]}};
        lane_en   = st_offset[1] ? 4'b1100 : 4'b0011;
      end
      ACC_WORD:
      begin
        lane_data = st_data;
        lane_en   = 4'b1111;
      end
      default:
      begin
        lane_data = st_data;
        lane_en   = 4'b0000;  // Unknown type writes nothing
      end
    endcase
  end

  // Data copied to every word, enables pick the lane
  assign store_line = {WORDS_PER_LINE{lane_data}};
  assign store_en   = byte_en_t'(lane_en) << {st_offset[3:2], 2'b00};

endmodule

`default_nettype wire

/* verilog/l1d_valid_bits.sv */
`timescale 1ns/10ps
`default_nettype none

module l1d_valid_bits (
  input  logic              clk,
  input  logic              rst,
  input  l1d_pkg::index_t   index,
  input  logic              valid_set,
  output logic              valid
);
  import l1d_pkg::*;

  logic [LINES-1:0] flags;

  // Read registered to line up with the arrays
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      flags <= '0;
      valid <= 1'b0;
    end
    else
    begin
      if (valid_set)
        flags[index] <= 1'b1;
      valid <= flags[index];
    end
  end

endmodule

`default_nettype wire

/* verilog/l1d_pkg.sv */
`default_nettype none

package l1d_pkg;

  // ====================
  // Address split and widths
  // ====================
  localparam int ADDR_W         = 32;
  localparam int WORD_W         = 32;
  localparam int TAG_W          = 22;
  localparam int INDEX_W        = 6;
  localparam int OFFSET_W       = 4;
  localparam int LINES          = 64;
  localparam int LINE_W         = 128;
  localparam int LINE_BYTES     = 16;
  localparam int WORDS_PER_LINE = 4;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [INDEX_W-1:0]    index_t;
  typedef logic [OFFSET_W-1:0]   offset_t;
  typedef logic [LINE_W-1:0]     line_t;
  typedef logic [LINE_BYTES-1:0] byte_en_t;  // One bit per byte, active high
  typedef logic [2:0]            access_t;

  // Access types on core_type and D_type
  localparam access_t ACC_BYTE   = 3'd0;
  localparam access_t ACC_HALF   = 3'd1;
  localparam access_t ACC_WORD   = 3'd2;
  localparam access_t ACC_BYTE_U = 3'd4;
  localparam access_t ACC_HALF_U = 3'd5;

  typedef enum logic [2:0] {
    st_idle,
    st_check_read,
    st_refill,       // Four word beats from memory
    st_install,
    st_check_write,
    st_write_mem     // Write-through beat
  } ctrl_state_t;

endpackage

`default_nettype wire
